//--- pgwr_defines.svh
// compile-time constants for the page-table write manager
// table bases, entry counts, pointer width and the outstanding write limit
// include wherever one of the PGWR_* values is needed

`ifndef PGWR_DEFINES_SVH
`define PGWR_DEFINES_SVH

// att entry 1 sits at the first byte of this line
`define PGWR_ATT_BASE 64'h0000_0000_8000_0000

// list entry 1, placed after the 8 att lines
`define PGWR_LIST_BASE 64'h0000_0000_8000_1000

// first physical page handed out as a way (4KB page number)
`define PGWR_PPA_BASE 50'h0_0000_0008_0000

`define PGWR_ATT_CNT 64 // att entries, 8 per line
`define PGWR_LST_CNT 32 // list entries, 4 per line

// list and att pointers, 0 is null
`define PGWR_PTR_W 24

// writes in flight before the sequencer stalls
`define PGWR_MAX_OUTST 4

`endif

//--- pgwr_pkg.sv
// shared types of the page-table write manager
// command, job, table entry, list pointer and axi write channel structs

`include "pgwr_defines.svh"

package pgwr_pkg;

	typedef logic [`PGWR_PTR_W-1:0] ptr_t; // 0 = null

	// controller opcodes
	typedef enum logic [1:0] {
		OP_INIT_ATT,  // all att entries deallocated
		OP_INIT_LIST, // one long free list
		OP_ATT_STS,   // status write to one att entry
		OP_MOVE       // free head -> uncompressed tail
	} pgwr_op_e;

	typedef enum logic [1:0] {
		STS_DALLOC,
		STS_UNCOMP,
		STS_COMP
	} att_sts_e;

	typedef struct packed {
		pgwr_op_e op;
		ptr_t     att_id;
		att_sts_e sts;
	} pgwr_cmd_t; // 28 bits

	// job handed from decode to the sequencer with a one-cycle start
	typedef struct packed {
		pgwr_op_e op;
		ptr_t     att_id;
		att_sts_e sts;
	} pgwr_job_t;

	// 64-bit att entry, sts in the low bits
	typedef struct packed {
		logic [11:0] zpd_cnt;
		logic [49:0] way;
		att_sts_e    sts;
	} att_entry_t;

	// 128-bit list slot, next in the low 24 bits
	typedef struct packed {
		logic [5:0]  rsvd;
		logic [49:0] way;
		ptr_t        att_id;
		ptr_t        prev;
		ptr_t        next;
	} lst_entry_t;

	typedef struct packed {
		ptr_t free_head;
		ptr_t free_tail;
		ptr_t unc_head;
		ptr_t unc_tail;
	} lst_ptr_t; // 96 bits

	typedef struct packed {
		logic [63:0] addr;
	} axi_aw_t;

	typedef struct packed {
		logic [511:0] data; // one 64-byte line
		logic [63:0]  strb;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp; // 0 = okay
	} axi_b_t;

endpackage

//--- pgwr_cmd_decode.sv
// four-phase req/ack slave toward the controller
// latches a command, starts one job and acks once the job is done and drained

`timescale 1ns/10ps

module pgwr_cmd_decode (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 cmd_req,
	input  pgwr_pkg::pgwr_cmd_t  cmd,
	output logic                 cmd_ack,
	output logic                 job_start,
	output pgwr_pkg::pgwr_job_t  job,
	input  logic                 job_done,
	input  logic                 all_idle
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_BUSY,    // job running or responses pending
		S_ACK,     // ack high until req drops
		S_RELEASE  // one cycle with ack low
	} state_e;

	state_e state_q;
	logic   done_seen_q; // job_done seen while responses were still out

	assign cmd_ack = (state_q == S_ACK);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q     <= S_IDLE;
			done_seen_q <= 1'b0;
			job_start   <= 1'b0;
		end else begin
			job_start <= 1'b0; // single-cycle pulse
			unique case (state_q)
				S_IDLE: begin
					done_seen_q <= 1'b0;
					if (cmd_req) begin
						job_start <= 1'b1;
						state_q   <= S_BUSY;
					end
				end
				S_BUSY: begin
					if (job_done)
						done_seen_q <= 1'b1;
					if ((done_seen_q || job_done) && all_idle)
						state_q <= S_ACK; // every bresp is back
				end
				S_ACK:     if (!cmd_req) state_q <= S_RELEASE; // ack falls next cycle
				S_RELEASE: state_q <= S_IDLE;
			endcase
		end
	end

	// command is stable while req is high, so copy it at the start
	always_ff @(posedge clk_i) begin
		if (state_q == S_IDLE && cmd_req) begin
			job.op     <= cmd.op;
			job.att_id <= cmd.att_id;
			job.sts    <= cmd.sts;
		end
	end

endmodule

//--- pgwr_chan_slice.sv
// one-entry valid/ready holding register for an axi request channel
// payload_t selects the channel, data shows on out_data the cycle after the load

`timescale 1ns/10ps

module pgwr_chan_slice #(
	parameter type payload_t = logic
) (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     full_q;
	payload_t data_q;
	logic     load;

	assign in_ready  = !full_q; // accepts only when empty, no pass-through
	assign load      = in_valid && in_ready;
	assign out_valid = full_q;
	assign out_data  = data_q;

	// valid holds until the bus takes the beat
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			full_q <= 1'b0;
		end else if (load) begin
			full_q <= 1'b1;
		end else if (out_ready) begin
			full_q <= 1'b0; // beat taken
		end
	end

	// payload stays still while full
	always_ff @(posedge clk_i) begin
		if (load)
			data_q <= in_data;
	end

endmodule

//--- pgwr_wr_tracker.sv
// counts accepted write addresses against returned responses
// gives the issue window, the drained flag and a sticky bus error

`timescale 1ns/10ps
`include "pgwr_defines.svh"

module pgwr_wr_tracker (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              aw_fire,
	input  logic              bvalid,
	input  pgwr_pkg::axi_b_t  bresp,
	output logic              can_issue,
	output logic              all_idle,
	output logic              bus_error
);

	localparam int unsigned CNT_W = $clog2(`PGWR_MAX_OUTST + 1);

	logic [CNT_W-1:0] outst_q; // writes with no response yet
	logic             stray_b; // response with nothing outstanding
	logic             b_take;

	assign stray_b = bvalid && (outst_q == '0);
	assign b_take  = bvalid && !stray_b;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			outst_q   <= '0;
			bus_error <= 1'b0;
		end else begin
			unique case ({aw_fire, b_take})
				2'b10:   outst_q <= outst_q + 1'b1;
				2'b01:   outst_q <= outst_q - 1'b1;
				default: outst_q <= outst_q; // none, or one in and one out
			endcase
			if (bvalid && (bresp.resp != 2'b00 || stray_b))
				bus_error <= 1'b1; // held until reset
		end
	end

	assign can_issue = (outst_q < CNT_W'(`PGWR_MAX_OUTST));
	assign all_idle  = (outst_q == '0);

endmodule

//--- pgwr_tbl_sequencer.sv
// execute stage: forms every att and list table line write for a job
// owns the free and uncompressed list pointers and the init done flags
// one line goes into the aw/w slices per handshake, job_done after the drain

`timescale 1ns/10ps
`include "pgwr_defines.svh"

module pgwr_tbl_sequencer (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 job_start,
	input  pgwr_pkg::pgwr_job_t  job,
	output logic                 job_done,
	output pgwr_pkg::axi_aw_t    aw_data,
	output pgwr_pkg::axi_w_t     w_data,
	output logic                 line_valid,
	input  logic                 line_ready,
	input  logic                 can_issue,
	output pgwr_pkg::lst_ptr_t   lst_ptr,
	output logic                 init_att_done,
	output logic                 init_list_done
);

	import pgwr_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE, // lines going out
		S_DRAIN  // wait for both slices to empty
	} state_e;

	// write steps of one allocation move
	typedef enum logic [1:0] {
		MV_ATT,  // att entry gets way and uncomp status
		MV_POP,  // new free head loses its prev
		MV_PUSH, // moved entry linked behind unc tail
		MV_LINK  // old unc tail points to moved entry
	} mv_step_e;

	state_e     state_q;
	mv_step_e   step_q, step_nxt;
	pgwr_job_t  job_q;
	ptr_t       cnt_q;       // entry id during init walks
	ptr_t       line_id;     // entry written by the current line
	ptr_t       line_idx;    // line_id - 1
	logic       line_is_att;
	logic       line_last;
	att_entry_t att_ent;
	lst_entry_t lst_ent;
	logic [15:0] lst_mask;   // byte enables inside the 128-bit list slot
	logic       free_last;   // popping the only free entry

	assign free_last  = (lst_ptr.free_head == lst_ptr.free_tail);
	assign line_valid = (state_q == S_ISSUE) && can_issue && line_ready;

	// entry contents for the current line
	always_comb begin
		line_id     = cnt_q;
		line_is_att = 1'b1;
		line_last   = 1'b0;
		att_ent     = '0;
		lst_ent     = '0;
		lst_mask    = 16'hffff;
		step_nxt    = step_q;
		unique case (job_q.op)
			OP_INIT_ATT: line_last = (cnt_q == `PGWR_ATT_CNT); // deallocated, way 0
			OP_INIT_LIST: begin
				line_is_att  = 1'b0;
				lst_ent.prev = cnt_q - 1'b1; // entry 1 gets null
				lst_ent.next = (cnt_q == `PGWR_LST_CNT) ? '0 : cnt_q + 1'b1;
				lst_ent.way  = `PGWR_PPA_BASE + 50'(cnt_q) - 50'd1;
				line_last    = (cnt_q == `PGWR_LST_CNT);
			end
			OP_ATT_STS: begin
				line_id     = job_q.att_id;
				att_ent.sts = job_q.sts; // way and zpd count cleared
				line_last   = 1'b1;
			end
			OP_MOVE: begin
				unique case (step_q)
					MV_ATT: begin
						line_id     = job_q.att_id;
						att_ent.way = `PGWR_PPA_BASE + 50'(lst_ptr.free_head) - 50'd1;
						att_ent.sts = STS_UNCOMP;
						step_nxt    = free_last ? MV_PUSH : MV_POP;
					end
					MV_POP: begin
						line_is_att = 1'b0;
						line_id     = lst_ptr.free_head + 1'b1; // free list is in order
						lst_mask    = 16'h0038;                 // prev bytes only
						step_nxt    = MV_PUSH;
					end
					MV_PUSH: begin
						line_is_att    = 1'b0;
						line_id        = lst_ptr.free_head;
						lst_ent.prev   = lst_ptr.unc_tail;
						lst_ent.att_id = job_q.att_id;
						lst_mask       = 16'h01ff; // next, prev, att_id
						line_last      = (lst_ptr.unc_tail == '0);
						step_nxt       = MV_LINK;
					end
					MV_LINK: begin
						line_is_att  = 1'b0;
						line_id      = lst_ptr.unc_tail;
						lst_ent.next = lst_ptr.free_head;
						lst_mask     = 16'h0007; // next bytes only
						line_last    = 1'b1;
					end
				endcase
			end
		endcase
	end

	// place the entry into its 64-byte line
	always_comb begin
		line_idx = line_id - 1'b1;
		if (line_is_att) begin
			aw_data.addr = `PGWR_ATT_BASE + (64'(line_idx[`PGWR_PTR_W-1:3]) << 6);
			w_data.data  = 512'(att_ent) << (64 * line_idx[2:0]); // 8 entries per line
			w_data.strb  = 64'hff << (8 * line_idx[2:0]);
		end else begin
			aw_data.addr = `PGWR_LIST_BASE + (64'(line_idx[`PGWR_PTR_W-1:2]) << 6);
			w_data.data  = 512'(lst_ent) << (128 * line_idx[1:0]); // 4 entries per line
			w_data.strb  = 64'(lst_mask) << (16 * line_idx[1:0]);
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q        <= S_IDLE;
			step_q         <= MV_ATT;
			cnt_q          <= '0;
			job_done       <= 1'b0;
			lst_ptr        <= '0; // all lists null
			init_att_done  <= 1'b0;
			init_list_done <= 1'b0;
		end else begin
			job_done <= 1'b0;
			unique case (state_q)
				S_IDLE: begin
					if (job_start) begin
						cnt_q  <= ptr_t'(1);
						step_q <= MV_ATT;
						// empty free list, nothing to write
						if (job.op == OP_MOVE && lst_ptr.free_head == '0)
							state_q <= S_DRAIN;
						else
							state_q <= S_ISSUE;
					end
				end
				S_ISSUE: begin
					if (line_valid) begin
						cnt_q  <= cnt_q + 1'b1;
						step_q <= step_nxt;
						if (line_last)
							state_q <= S_DRAIN;
					end
				end
				S_DRAIN: begin
					if (line_ready) begin // last line has left both slices
						job_done <= 1'b1;
						state_q  <= S_IDLE;
						unique case (job_q.op)
							OP_INIT_ATT: init_att_done <= 1'b1;
							OP_INIT_LIST: begin
								init_list_done    <= 1'b1;
								lst_ptr.free_head <= ptr_t'(1);
								lst_ptr.free_tail <= ptr_t'(`PGWR_LST_CNT);
								lst_ptr.unc_head  <= '0;
								lst_ptr.unc_tail  <= '0;
							end
							OP_ATT_STS: ;
							OP_MOVE: begin
								if (lst_ptr.free_head != '0) begin
									lst_ptr.unc_tail <= lst_ptr.free_head;
									if (lst_ptr.unc_head == '0)
										lst_ptr.unc_head <= lst_ptr.free_head;
									if (free_last) begin
										lst_ptr.free_head <= '0;
										lst_ptr.free_tail <= '0;
									end else begin
										lst_ptr.free_head <= lst_ptr.free_head + 1'b1;
									end
								end
							end
						endcase
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == S_IDLE && job_start)
			job_q <= job;
	end

endmodule

//--- pgwr_top.sv
// page-table write manager top
// command decode, table sequencer, aw/w holding slices and the response tracker

`timescale 1ns/10ps

module pgwr_top (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  logic                cmd_req,
	input  pgwr_pkg::pgwr_cmd_t cmd,
	output logic                cmd_ack,
	output logic                awvalid,
	input  logic                awready,
	output pgwr_pkg::axi_aw_t   aw,
	output logic                wvalid,
	input  logic                wready,
	output pgwr_pkg::axi_w_t    w,
	input  logic                bvalid,
	input  pgwr_pkg::axi_b_t    bresp,
	output logic                bready,
	output pgwr_pkg::lst_ptr_t  lst_ptr,
	output logic                init_att_done,
	output logic                init_list_done,
	output logic                bus_error
);

	import pgwr_pkg::*;

	pgwr_job_t job;
	logic      job_start;
	logic      job_done;
	axi_aw_t   aw_line;
	axi_w_t    w_line;
	logic      line_valid;
	logic      line_ready;
	logic      aw_in_ready;
	logic      w_in_ready;
	logic      can_issue;
	logic      all_idle;
	logic      aw_fire;

	assign line_ready = aw_in_ready & w_in_ready; // both slices empty
	assign aw_fire    = awvalid & awready;
	assign bready     = 1'b1; // responses always taken

	pgwr_cmd_decode u_cmd_decode (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.cmd_req   (cmd_req),
		.cmd       (cmd),
		.cmd_ack   (cmd_ack),
		.job_start (job_start),
		.job       (job),
		.job_done  (job_done),
		.all_idle  (all_idle)
	);

	pgwr_tbl_sequencer u_tbl_sequencer (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.job_start      (job_start),
		.job            (job),
		.job_done       (job_done),
		.aw_data        (aw_line),
		.w_data         (w_line),
		.line_valid     (line_valid),
		.line_ready     (line_ready),
		.can_issue      (can_issue),
		.lst_ptr        (lst_ptr),
		.init_att_done  (init_att_done),
		.init_list_done (init_list_done)
	);

	pgwr_chan_slice #(.payload_t(axi_aw_t)) u_aw_slice (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.in_valid  (line_valid),
		.in_ready  (aw_in_ready),
		.in_data   (aw_line),
		.out_valid (awvalid),
		.out_ready (awready),
		.out_data  (aw)
	);

	pgwr_chan_slice #(.payload_t(axi_w_t)) u_w_slice (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.in_valid  (line_valid),
		.in_ready  (w_in_ready),
		.in_data   (w_line),
		.out_valid (wvalid),
		.out_ready (wready),
		.out_data  (w)
	);

	pgwr_wr_tracker u_wr_tracker (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.aw_fire   (aw_fire),
		.bvalid    (bvalid),
		.bresp     (bresp),
		.can_issue (can_issue),
		.all_idle  (all_idle),
		.bus_error (bus_error)
	);

endmodule

//--- pgwr_assertions.sv
// protocol checks bound into every pgwr_top instance
// req/ack ordering, aw/w stability under stalls, responses only for open writes

`timescale 1ns/10ps

module pgwr_assertions (
	input logic                clk_i,
	input logic                rst_ni,
	input logic                cmd_req,
	input pgwr_pkg::pgwr_cmd_t cmd,
	input logic                cmd_ack,
	input logic                awvalid,
	input logic                awready,
	input pgwr_pkg::axi_aw_t   aw,
	input logic                wvalid,
	input logic                wready,
	input pgwr_pkg::axi_w_t    w,
	input logic                bvalid
);

	int unsigned fail_cnt = 0; // failed assertions, summed by the testbench
	int          outst_q;      // writes seen on aw with no response yet

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni)
			outst_q <= 0;
		else
			outst_q <= outst_q + int'(awvalid && awready) - int'(bvalid);
	end

	aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		awvalid && !awready |=> awvalid && $stable(aw))
		else begin
			fail_cnt++;
			$error("aw valid dropped or payload moved while stalled");
		end

	w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wvalid && !wready |=> wvalid && $stable(w))
		else begin
			fail_cnt++;
			$error("w valid dropped or payload moved while stalled");
		end

	// four-phase order, ack only inside a request and gone one cycle after it
	ack_in_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$rose(cmd_ack) |-> cmd_req)
		else begin
			fail_cnt++;
			$error("cmd_ack rose without cmd_req");
		end

	ack_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
		cmd_ack && cmd_req |=> cmd_ack)
		else begin
			fail_cnt++;
			$error("cmd_ack fell while cmd_req still high");
		end

	ack_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$fell(cmd_req) |=> !cmd_ack)
		else begin
			fail_cnt++;
			$error("cmd_ack still high one cycle after cmd_req fell");
		end

	req_after_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$rose(cmd_req) |-> !cmd_ack && $past(!cmd_ack))
		else begin
			fail_cnt++;
			$error("new cmd_req before cmd_ack was low");
		end

	cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		cmd_req && $past(cmd_req) |-> $stable(cmd))
		else begin
			fail_cnt++;
			$error("cmd changed while cmd_req was high");
		end

	no_stray_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bvalid |-> outst_q > 0)
		else begin
			fail_cnt++;
			$error("bvalid with no write outstanding");
		end

endmodule

bind pgwr_top pgwr_assertions u_pgwr_assertions (
	.clk_i   (clk_i),
	.rst_ni  (rst_ni),
	.cmd_req (cmd_req),
	.cmd     (cmd),
	.cmd_ack (cmd_ack),
	.awvalid (awvalid),
	.awready (awready),
	.aw      (aw),
	.wvalid  (wvalid),
	.wready  (wready),
	.w       (w),
	.bvalid  (bvalid)
);

//--- tb_pgwr.sv
// testbench for the page-table write manager
// runs commands over req/ack against a memory model with random stalls
// every captured line is compared with a reference built from the table layout

`timescale 1ns/10ps
`include "pgwr_defines.svh"

module tb_pgwr;

	import pgwr_pkg::*;

	typedef struct packed {
		logic [63:0]  addr;
		logic [63:0]  strb;
		logic [511:0] data;
	} line_t;

	localparam int WAIT_LIM = 5000; // cycles allowed for any single wait

	logic        clk_i;
	logic        rst_ni;
	logic        cmd_req;
	pgwr_cmd_t   cmd;
	logic        cmd_ack;
	logic        awvalid;
	logic        awready;
	axi_aw_t     aw;
	logic        wvalid;
	logic        wready;
	axi_w_t      w;
	logic        bvalid;
	axi_b_t      bresp;
	logic        bready;
	lst_ptr_t    lst_ptr;
	logic        init_att_done;
	logic        init_list_done;
	logic        bus_error;

	line_t       got_q[$];  // lines seen on the bus, aw and w paired in order
	line_t       exp_q[$];  // lines the reference expects
	logic [63:0] aw_q[$];
	axi_w_t      w_q[$];
	int          due_q[$];  // cycle each response may go out
	logic [1:0]  resp_q[$];
	logic [31:0] rng;
	int          cyc;
	logic        err_mode;  // answer new writes with slverr
	int          errors;
	int          checks;
	lst_ptr_t    model;     // reference list pointers

	pgwr_top u_pgwr_top (.*);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// memory model, random ready on aw/w and a 1 to 4 cycle bresp delay
	always @(posedge clk_i) begin : mem_resp
		line_t  ln;
		axi_w_t wb;
		cyc++;
		rng = xorshift32(rng);
		awready <= (rng[1:0] != 2'b00);
		wready  <= (rng[3:2] != 2'b00);
		if (awvalid && awready)
			aw_q.push_back(aw.addr);
		if (wvalid && wready)
			w_q.push_back(w);
		if (aw_q.size() > 0 && w_q.size() > 0) begin
			wb      = w_q.pop_front();
			ln.addr = aw_q.pop_front();
			ln.strb = wb.strb;
			ln.data = wb.data;
			got_q.push_back(ln);
			due_q.push_back(cyc + 1 + int'(rng[5:4]));
			resp_q.push_back(err_mode ? 2'b10 : 2'b00);
		end
		bvalid     <= 1'b0;
		bresp.resp <= 2'b00;
		if (due_q.size() > 0 && due_q[0] <= cyc) begin
			bvalid     <= 1'b1;
			bresp.resp <= resp_q.pop_front();
			void'(due_q.pop_front());
		end
	end

	task automatic expect_eq(input string what, input logic [575:0] got,
			input logic [575:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERR %s got %0h exp %0h", what, got, exp);
			errors++;
		end
	endtask

	// att entry id lives in 64-bit slot (id-1)%8 of line (id-1)/8
	function automatic line_t att_line(input int id, input att_entry_t ent);
		line_t l;
		int    slot;
		slot   = (id - 1) % 8;
		l.addr = `PGWR_ATT_BASE + 64'((id - 1) / 8) * 64'd64;
		l.strb = 64'hff << (8 * slot);
		l.data = 512'(ent) << (64 * slot);
		return l;
	endfunction

	// list entry id lives in 128-bit slot (id-1)%4, be picks the bytes written
	function automatic line_t lst_line(input int id, input lst_entry_t ent,
			input logic [15:0] be);
		line_t l;
		int    slot;
		slot   = (id - 1) % 4;
		l.addr = `PGWR_LIST_BASE + 64'((id - 1) / 4) * 64'd64;
		l.strb = 64'(be) << (16 * slot);
		l.data = 512'(ent) << (128 * slot);
		return l;
	endfunction

	function automatic logic [511:0] keep_bytes(input line_t l);
		logic [511:0] d;
		for (int b = 0; b < 64; b++)
			d[8*b +: 8] = l.strb[b] ? l.data[8*b +: 8] : 8'h00; // unwritten bytes ignored
		return d;
	endfunction

	task automatic check_lines(input string tag);
		int n;
		expect_eq({tag, " write count"}, got_q.size(), exp_q.size());
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++) begin
			expect_eq($sformatf("%s aw.addr[%0d]", tag, i), got_q[i].addr, exp_q[i].addr);
			expect_eq($sformatf("%s w.strb[%0d]", tag, i), got_q[i].strb, exp_q[i].strb);
			expect_eq($sformatf("%s w.data[%0d]", tag, i), keep_bytes(got_q[i]),
				keep_bytes(exp_q[i]));
		end
		got_q.delete();
		exp_q.delete();
	endtask

	// pop the free head, record it in att entry id, append it to the unc list
	task automatic expect_move(input int id);
		att_entry_t ae;
		lst_entry_t le;
		ptr_t       fh;
		fh = model.free_head;
		if (fh != '0) begin
			ae     = '0;
			ae.way = `PGWR_PPA_BASE + 50'(fh) - 50'd1;
			ae.sts = STS_UNCOMP;
			exp_q.push_back(att_line(id, ae));
			le = '0;
			if (fh != model.free_tail)
				exp_q.push_back(lst_line(int'(fh) + 1, le, 16'h0038)); // prev := null
			le.prev   = model.unc_tail;
			le.att_id = ptr_t'(id);
			exp_q.push_back(lst_line(int'(fh), le, 16'h01ff)); // next null, prev, att_id
			if (model.unc_tail != '0) begin
				le      = '0;
				le.next = fh;
				exp_q.push_back(lst_line(int'(model.unc_tail), le, 16'h0007));
			end
			model.unc_tail = fh;
			if (model.unc_head == '0)
				model.unc_head = fh;
			if (fh == model.free_tail) begin
				model.free_head = '0;
				model.free_tail = '0;
			end else begin
				model.free_head = fh + 1'b1;
			end
		end
	endtask

	// one full four-phase command, called and left on a rising edge
	task automatic run_cmd(input pgwr_op_e op, input int id, input att_sts_e sts);
		int n;
		cmd_req    <= 1'b1;
		cmd.op     <= op;
		cmd.att_id <= ptr_t'(id);
		cmd.sts    <= sts;
		n = 0;
		do begin
			@(posedge clk_i);
			n++;
		end while (!cmd_ack && n < WAIT_LIM);
		if (!cmd_ack) begin
			$display("timeout while waiting for cmd_ack to rise");
			errors++;
		end
		cmd_req <= 1'b0;
		n = 0;
		do begin
			@(posedge clk_i);
			n++;
		end while (cmd_ack && n < WAIT_LIM);
		if (cmd_ack) begin
			$display("timeout while waiting for cmd_ack to fall");
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before)
			$display("test %s: pass", name);
		else
			$display("test %s: %0d errors", name, errors - err_before);
	endtask

	initial begin
		int         e0;
		int         id;
		lst_entry_t le;
		att_entry_t ae;
		rng      = 32'd62181;
		cyc      = 0;
		errors   = 0;
		checks   = 0;
		err_mode = 1'b0;
		model    = '0;
		rst_ni   = 1'b0;
		cmd_req  = 1'b0;
		cmd      = '0;
		awready  = 1'b0;
		wready   = 1'b0;
		bvalid   = 1'b0;
		bresp    = '0;
		repeat (5) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(posedge clk_i);

		e0 = errors;
		expect_eq("cmd_ack", cmd_ack, 1'b0);
		expect_eq("awvalid", awvalid, 1'b0);
		expect_eq("wvalid", wvalid, 1'b0);
		expect_eq("bready", bready, 1'b1);
		expect_eq("init_att_done", init_att_done, 1'b0);
		expect_eq("init_list_done", init_list_done, 1'b0);
		expect_eq("bus_error", bus_error, 1'b0);
		expect_eq("lst_ptr", lst_ptr, '0);
		report_test("reset", e0);

		e0 = errors;
		for (id = 1; id <= `PGWR_ATT_CNT; id++)
			exp_q.push_back(att_line(id, '0)); // deallocated, way zero
		run_cmd(OP_INIT_ATT, 0, STS_DALLOC);
		check_lines("init_att");
		expect_eq("init_att_done", init_att_done, 1'b1);
		report_test("init_att", e0);

		e0 = errors;
		for (id = 1; id <= `PGWR_LST_CNT; id++) begin
			le      = '0;
			le.prev = ptr_t'(id - 1);
			le.next = (id == `PGWR_LST_CNT) ? '0 : ptr_t'(id + 1);
			le.way  = `PGWR_PPA_BASE + 50'(id - 1);
			exp_q.push_back(lst_line(id, le, 16'hffff));
		end
		run_cmd(OP_INIT_LIST, 0, STS_DALLOC);
		check_lines("init_list");
		model.free_head = ptr_t'(1);
		model.free_tail = ptr_t'(`PGWR_LST_CNT);
		expect_eq("init_list_done", init_list_done, 1'b1);
		expect_eq("lst_ptr", lst_ptr, model);
		report_test("init_list", e0);

		// one move per free entry, then one more on the empty list
		e0 = errors;
		for (int k = 0; k <= `PGWR_LST_CNT; k++) begin
			id = ((k * 13) % `PGWR_ATT_CNT) + 1;
			expect_move(id);
			run_cmd(OP_MOVE, id, STS_UNCOMP);
			check_lines($sformatf("move%0d", k));
			expect_eq("lst_ptr", lst_ptr, model);
		end
		report_test("move", e0);

		e0 = errors;
		ae     = '0;
		ae.sts = STS_COMP;
		exp_q.push_back(att_line(9, ae));
		run_cmd(OP_ATT_STS, 9, STS_COMP);
		check_lines("att_sts");
		report_test("att_sts", e0);

		e0 = errors;
		err_mode = 1'b1;
		ae.sts   = STS_UNCOMP;
		exp_q.push_back(att_line(17, ae));
		run_cmd(OP_ATT_STS, 17, STS_UNCOMP);
		check_lines("slverr");
		expect_eq("bus_error", bus_error, 1'b1);
		err_mode = 1'b0;
		ae.sts   = STS_DALLOC;
		exp_q.push_back(att_line(17, ae));
		run_cmd(OP_ATT_STS, 17, STS_DALLOC);
		check_lines("after_err");
		expect_eq("bus_error", bus_error, 1'b1); // sticky
		report_test("bus_error", e0);

		errors += u_pgwr_top.u_pgwr_assertions.fail_cnt;
		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- list.f
+incdir+.
pgwr_pkg.sv
pgwr_cmd_decode.sv
pgwr_chan_slice.sv
pgwr_wr_tracker.sv
pgwr_tbl_sequencer.sv
pgwr_top.sv
pgwr_assertions.sv
tb_pgwr.sv

//--- Bender.yml
package:
  name: pgwr

sources:
  - include_dirs:
      - .
    files:
      - pgwr_pkg.sv
      - pgwr_cmd_decode.sv
      - pgwr_chan_slice.sv
      - pgwr_wr_tracker.sv
      - pgwr_tbl_sequencer.sv
      - pgwr_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - pgwr_assertions.sv
      - tb_pgwr.sv
